// File: snes_mem_defines.svh
// widths, wram bank prefix and map-control code for the snes memory front-end
`ifndef SNES_MEM_DEFINES_SVH
`define SNES_MEM_DEFINES_SVH

// sdram byte address, whole 16 MB space
`define SNES_ADDR_W 24

// wram is 128 KB on the console side
`define WRAM_ADDR_W 17

// bsram (save ram) byte address as driven by the core
`define BSRAM_ADDR_W 20

// upper 7 address bits that park wram near the top of sdram
// (prefix plus WRAM_ADDR_W must make SNES_ADDR_W)
`define WRAM_BANK_PREFIX 7'b1110111

// map_ctrl[7:4] value of the special map mode
// bsram reads here need only chip enable, rd_n is ignored
`define MAP_BSRAM_OPEN_READ 4'hC

`endif

// File: snes_mem_pkg.sv
// snes memory front-end package: sdram address, byte-lane and request-source types
`include "snes_mem_defines.svh"

package snes_mem_pkg;

    // byte address into sdram
    typedef logic [`SNES_ADDR_W-1:0] snes_addr_t;

    // lane enables, bit 1 high byte, bit 0 low byte
    typedef logic [1:0] byte_lanes_t;

    // who owns the sdram request slot this cycle
    typedef enum logic [1:0] {
        SRC_NONE   = 2'd0,  // idle, request bus zeroed
        SRC_LOADER = 2'd1,  // cartridge byte write, top priority
        SRC_ROM    = 2'd2,  // rom word read on phase_f
        SRC_WRAM   = 2'd3   // wram read or write, port 1
    } req_src_e;

endpackage

// File: loader_addr_counter.sv
// cartridge loader byte-address counter, restarts on each rising edge of loading
`timescale 1ns/100ps
`include "snes_mem_defines.svh"

module loader_addr_counter (
    input  logic                     wclk,
    input  logic                     resetn,
    input  logic                     loading,       // high for the whole load
    input  logic                     loader_valid,  // one strobe per cartridge byte
    output snes_mem_pkg::snes_addr_t loader_addr
);

    import snes_mem_pkg::*;

    logic loading_q;   // last cycle's loading level
    logic load_start;  // first cycle of a new load

    assign load_start = loading & ~loading_q;

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            loading_q   <= 1'b0;
            loader_addr <= '0;
        end else begin
            loading_q <= loading;
            // restart beats counting, a byte in the same cycle is dropped from the count
            if (load_start) begin
                loader_addr <= '0;
            end else if (loader_valid) begin
                loader_addr <= loader_addr + snes_addr_t'(1);  // next byte slot
            end
        end
    end

endmodule

// File: sdram_req_arbiter.sv
// run enable, phase strobes, fixed-priority sdram request mux and rom/wram read steering
`timescale 1ns/100ps
`include "snes_mem_defines.svh"

module sdram_req_arbiter (
    input  logic                      wclk,
    input  logic                      resetn,
    input  logic                      sdram_busy,    // controller still initialising
    input  logic                      loader_fail,
    input  logic                      frame_pause,   // hold core for frame sync
    input  logic                      sysclkf_ce,    // core fall phase enable
    input  logic                      sysclkr_ce,    // core rise phase enable
    input  logic                      loading,
    input  logic                      loader_valid,
    input  logic [7:0]                loader_data,
    input  snes_mem_pkg::snes_addr_t  loader_addr,
    input  snes_mem_pkg::snes_addr_t  rom_addr,
    input  logic                      rom_ce_n,
    input  logic                      rom_word,      // 16-bit rom fetch
    input  logic [`WRAM_ADDR_W-1:0]   wram_addr,
    input  logic                      wram_ce_n,
    input  logic                      wram_rd_n,
    input  logic                      wram_we_n,
    input  logic [7:0]                wram_d,
    input  logic [15:0]               cpu_port0,     // sdram return, rom/loader side
    input  logic [15:0]               cpu_port1,     // sdram return, wram side
    output logic                      run_enable,
    output logic                      phase_f,
    output logic                      phase_r,
    output logic [15:0]               rom_q,
    output logic [7:0]                wram_q,
    output snes_mem_pkg::snes_addr_t  cpu_addr,
    output logic [15:0]               cpu_din,
    output snes_mem_pkg::byte_lanes_t cpu_ds,
    output logic                      cpu_port,
    output logic                      cpu_rd,
    output logic                      cpu_wr
);

    import snes_mem_pkg::*;

    logic     wram_rd;  // core wants a wram read
    logic     wram_wr;  // core wants a wram write
    req_src_e grant;    // winner for this cycle

    // single byte access: odd address on high lane
    function automatic byte_lanes_t lanes_for(input logic addr_lsb);
        return {addr_lsb, ~addr_lsb};
    endfunction

    assign wram_rd = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr = ~wram_ce_n & ~wram_we_n;

    // loader beats rom beats wram
    always_comb begin
        if (loading && loader_valid) begin
            grant = SRC_LOADER;
        end else if (!rom_ce_n && phase_f) begin
            grant = SRC_ROM;   // rom only fetched on the fall phase
        end else if (wram_rd || wram_wr) begin
            grant = SRC_WRAM;  // address goes out even off-phase, strobes wait
        end else begin
            grant = SRC_NONE;
        end
    end

    // run gate and phase strobes
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            run_enable <= 1'b0;
            phase_f    <= 1'b0;
            phase_r    <= 1'b0;
        end else begin
            run_enable <= ~(sdram_busy | loader_fail | frame_pause);
            phase_f    <= sysclkf_ce & run_enable;  // one cycle behind the core enable
            phase_r    <= sysclkr_ce & run_enable;
        end
    end

    // registered request, zeroed when nobody wins
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            cpu_rd   <= 1'b0;
            cpu_wr   <= 1'b0;
            cpu_addr <= '0;
            cpu_din  <= '0;
            cpu_ds   <= '0;
            cpu_port <= 1'b0;
        end else begin
            cpu_rd   <= 1'b0;
            cpu_wr   <= 1'b0;
            cpu_addr <= '0;
            cpu_din  <= '0;
            cpu_ds   <= '0;
            cpu_port <= 1'b0;
            case (grant)
                SRC_LOADER: begin
                    cpu_wr   <= 1'b1;
                    cpu_addr <= loader_addr;
                    cpu_din  <= {loader_data, loader_data};  // byte on both lanes
                    cpu_ds   <= lanes_for(loader_addr[0]);
                end
                SRC_ROM: begin
                    cpu_rd   <= 1'b1;
                    cpu_addr <= rom_addr;
                    cpu_ds   <= 2'b11;  // always a full word
                end
                SRC_WRAM: begin
                    cpu_addr <= {`WRAM_BANK_PREFIX, wram_addr};
                    cpu_din  <= {wram_d, wram_d};
                    cpu_ds   <= lanes_for(wram_addr[0]);
                    cpu_port <= 1'b1;               // wram data back on port 1
                    cpu_rd   <= wram_rd & phase_f;  // reads on fall
                    cpu_wr   <= wram_wr & phase_r;  // writes on rise
                end
                default: ;  // SRC_NONE, bus stays zero
            endcase
        end
    end

    // odd byte fetch swaps lanes unless the core asked for a word
    assign rom_q  = (rom_word || !rom_addr[0]) ? cpu_port0
                                               : {cpu_port0[7:0], cpu_port0[15:8]};
    assign wram_q = wram_addr[0] ? cpu_port1[15:8] : cpu_port1[7:0];

endmodule

// File: bsram_req_port.sv
// registered bsram (save ram) request port and bsram read byte select
`timescale 1ns/100ps
`include "snes_mem_defines.svh"

module bsram_req_port (
    input  logic                     wclk,
    input  logic                     resetn,
    input  logic                     phase_f,        // gated fall phase
    input  logic                     phase_r,        // gated rise phase
    input  logic [7:0]               map_ctrl,       // cartridge map-control byte
    input  logic [`BSRAM_ADDR_W-1:0] bsram_addr,
    input  logic                     bsram_ce_n,
    input  logic                     bsram_rd_n,
    input  logic                     bsram_we_n,
    input  logic [7:0]               bsram_d,
    input  logic [15:0]              bsram_dout,     // word from sdram
    output logic [7:0]               bsram_q,
    output logic [`BSRAM_ADDR_W-1:0] bsram_req_addr,
    output logic [7:0]               bsram_req_din,
    output logic                     bsram_req_rd,
    output logic                     bsram_req_wr
);

    logic open_read;  // map mode where rd_n is not driven
    logic rd_req;
    logic wr_req;

    assign open_read = (map_ctrl[7:4] == `MAP_BSRAM_OPEN_READ);
    assign rd_req    = ~bsram_ce_n & (~bsram_rd_n | open_read) & phase_f;
    assign wr_req    = ~bsram_ce_n & ~bsram_we_n & phase_r;

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            bsram_req_rd   <= 1'b0;
            bsram_req_wr   <= 1'b0;
            bsram_req_addr <= '0;
            bsram_req_din  <= '0;
        end else begin
            bsram_req_rd   <= rd_req;
            bsram_req_wr   <= wr_req;
            bsram_req_addr <= bsram_addr;  // follows the core every cycle
            bsram_req_din  <= bsram_d;
        end
    end

    // pick the byte by the live address, not the registered one
    assign bsram_q = bsram_addr[0] ? bsram_dout[15:8] : bsram_dout[7:0];

endmodule

// File: snes_mem_front.sv
// snes memory front-end top: loader counter, sdram request arbiter and bsram port
`timescale 1ns/100ps
`include "snes_mem_defines.svh"

module snes_mem_front (
    input  logic                      wclk,
    input  logic                      resetn,
    input  logic                      sdram_busy,
    input  logic                      loader_fail,
    input  logic                      frame_pause,
    input  logic                      sysclkf_ce,
    input  logic                      sysclkr_ce,
    input  logic                      loading,
    input  logic                      loader_valid,
    input  logic [7:0]                loader_data,
    input  logic [7:0]                map_ctrl,
    // rom side of the core
    input  snes_mem_pkg::snes_addr_t  rom_addr,
    input  logic                      rom_ce_n,
    input  logic                      rom_word,
    // wram side
    input  logic [`WRAM_ADDR_W-1:0]   wram_addr,
    input  logic                      wram_ce_n,
    input  logic                      wram_rd_n,
    input  logic                      wram_we_n,
    input  logic [7:0]                wram_d,
    // save ram side
    input  logic [`BSRAM_ADDR_W-1:0]  bsram_addr,
    input  logic                      bsram_ce_n,
    input  logic                      bsram_rd_n,
    input  logic                      bsram_we_n,
    input  logic [7:0]                bsram_d,
    // sdram return data
    input  logic [15:0]               cpu_port0,
    input  logic [15:0]               cpu_port1,
    input  logic [15:0]               bsram_dout,
    output logic                      run_enable,
    output logic [15:0]               rom_q,
    output logic [7:0]                wram_q,
    output logic [7:0]                bsram_q,
    // sdram requests
    output snes_mem_pkg::snes_addr_t  cpu_addr,
    output logic [15:0]               cpu_din,
    output snes_mem_pkg::byte_lanes_t cpu_ds,
    output logic                      cpu_port,
    output logic                      cpu_rd,
    output logic                      cpu_wr,
    output logic [`BSRAM_ADDR_W-1:0]  bsram_req_addr,
    output logic [7:0]                bsram_req_din,
    output logic                      bsram_req_rd,
    output logic                      bsram_req_wr
);

    import snes_mem_pkg::*;

    snes_addr_t loader_addr;  // counter to arbiter
    logic       phase_f;      // shared by arbiter and bsram port
    logic       phase_r;

    loader_addr_counter u_loader_addr_counter (
        .wclk         (wclk),
        .resetn       (resetn),
        .loading      (loading),
        .loader_valid (loader_valid),
        .loader_addr  (loader_addr)
    );

    sdram_req_arbiter u_sdram_req_arbiter (
        .wclk         (wclk),
        .resetn       (resetn),
        .sdram_busy   (sdram_busy),
        .loader_fail  (loader_fail),
        .frame_pause  (frame_pause),
        .sysclkf_ce   (sysclkf_ce),
        .sysclkr_ce   (sysclkr_ce),
        .loading      (loading),
        .loader_valid (loader_valid),
        .loader_data  (loader_data),
        .loader_addr  (loader_addr),
        .rom_addr     (rom_addr),
        .rom_ce_n     (rom_ce_n),
        .rom_word     (rom_word),
        .wram_addr    (wram_addr),
        .wram_ce_n    (wram_ce_n),
        .wram_rd_n    (wram_rd_n),
        .wram_we_n    (wram_we_n),
        .wram_d       (wram_d),
        .cpu_port0    (cpu_port0),
        .cpu_port1    (cpu_port1),
        .run_enable   (run_enable),
        .phase_f      (phase_f),
        .phase_r      (phase_r),
        .rom_q        (rom_q),
        .wram_q       (wram_q),
        .cpu_addr     (cpu_addr),
        .cpu_din      (cpu_din),
        .cpu_ds       (cpu_ds),
        .cpu_port     (cpu_port),
        .cpu_rd       (cpu_rd),
        .cpu_wr       (cpu_wr)
    );

    // save ram has its own sdram port, no arbitration needed
    bsram_req_port u_bsram_req_port (
        .wclk           (wclk),
        .resetn         (resetn),
        .phase_f        (phase_f),
        .phase_r        (phase_r),
        .map_ctrl       (map_ctrl),
        .bsram_addr     (bsram_addr),
        .bsram_ce_n     (bsram_ce_n),
        .bsram_rd_n     (bsram_rd_n),
        .bsram_we_n     (bsram_we_n),
        .bsram_d        (bsram_d),
        .bsram_dout     (bsram_dout),
        .bsram_q        (bsram_q),
        .bsram_req_addr (bsram_req_addr),
        .bsram_req_din  (bsram_req_din),
        .bsram_req_rd   (bsram_req_rd),
        .bsram_req_wr   (bsram_req_wr)
    );

endmodule

// File: tb_clock_gen.sv
// testbench clock and reset generator, 10 ns clock and 16-cycle reset
`timescale 1ns/100ps

module tb_clock_gen (
    output logic wclk,
    output logic resetn
);

    // free-running clock, 5 ns per half period
    initial begin
        wclk = 1'b0;
        forever #5 wclk = ~wclk;
    end

    initial begin
        resetn = 1'b0;
        repeat (16) @(posedge wclk);  // reset held for 16 rising edges
        resetn <= 1'b1;               // released on an edge like every other input
    end

endmodule

// File: snes_mem_front_tb.sv
// testbench top with stimulus, lfsr, sdram data model, reference phase model and assertions
`timescale 1ns/100ps
`include "snes_mem_defines.svh"

module snes_mem_front_tb;

    import snes_mem_pkg::*;

    typedef logic [`WRAM_ADDR_W-1:0]  wram_addr_t;
    typedef logic [`BSRAM_ADDR_W-1:0] bsram_addr_t;

    logic        wclk;
    logic        resetn;
    logic        sdram_busy;
    logic        loader_fail;
    logic        frame_pause;
    logic        sysclkf_ce;
    logic        sysclkr_ce;
    logic        loading;
    logic        loader_valid;
    logic [7:0]  loader_data;
    logic [7:0]  map_ctrl;
    snes_addr_t  rom_addr;
    logic        rom_ce_n;
    logic        rom_word;
    wram_addr_t  wram_addr;
    logic        wram_ce_n;
    logic        wram_rd_n;
    logic        wram_we_n;
    logic [7:0]  wram_d;
    bsram_addr_t bsram_addr;
    logic        bsram_ce_n;
    logic        bsram_rd_n;
    logic        bsram_we_n;
    logic [7:0]  bsram_d;
    logic [15:0] cpu_port0;
    logic [15:0] cpu_port1;
    logic [15:0] bsram_dout;
    logic        run_enable;
    logic [15:0] rom_q;
    logic [7:0]  wram_q;
    logic [7:0]  bsram_q;
    snes_addr_t  cpu_addr;
    logic [15:0] cpu_din;
    byte_lanes_t cpu_ds;
    logic        cpu_port;
    logic        cpu_rd;
    logic        cpu_wr;
    bsram_addr_t bsram_req_addr;
    logic [7:0]  bsram_req_din;
    logic        bsram_req_rd;
    logic        bsram_req_wr;

    logic [31:0] lfsr_state = 32'h95c9_2a80;  // seed
    snes_addr_t  exp_load_addr;               // byte index the stimulus is sending
    int unsigned rst_edges  = 0;              // edges seen in reset
    int unsigned live_edges = 0;              // edges seen since reset release
    logic        run_ref = 1'b0;              // run gate as the core should see it
    logic        phf_ref = 1'b0;
    logic        phr_ref = 1'b0;

    logic core_stop;
    logic load_beat;
    logic rom_sel;
    logic wram_rd_req;
    logic wram_wr_req;

    assign core_stop   = sdram_busy | loader_fail | frame_pause;
    assign load_beat   = loading & loader_valid;
    assign rom_sel     = ~rom_ce_n;
    assign wram_rd_req = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr_req = ~wram_ce_n & ~wram_we_n;

    tb_clock_gen u_clock_gen (
        .wclk   (wclk),
        .resetn (resetn)
    );

    snes_mem_front DUT (.*);

    // reset bookkeeping and the two-stage phase pipeline of the core interface
    always @(posedge wclk) begin
        if (!resetn) begin
            rst_edges  <= rst_edges + 1;
            live_edges <= 0;
            run_ref    <= 1'b0;
            phf_ref    <= 1'b0;
            phr_ref    <= 1'b0;
        end else begin
            live_edges <= live_edges + 1;
            run_ref    <= !core_stop;
            phf_ref    <= sysclkf_ce && run_ref;  // fall phase one cycle after the enable
            phr_ref    <= sysclkr_ce && run_ref;
        end
    end

    task automatic stop_on_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic flag_mismatch(input string what);
        $display("Mismatch at time %0t: %s", $time, what);
        stop_on_failure();
    endtask

    task automatic flag_timeout(input string what);
        $display("Timeout: %s", what);
        stop_on_failure();
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    reset_quiet_chk: assert property (@(posedge wclk)
        (rst_edges != 0 && live_edges == 0) |->
            (!cpu_rd && !cpu_wr && !bsram_req_rd && !bsram_req_wr && !run_enable))
        else flag_mismatch("strobes or run_enable not low around reset");

    run_enable_chk: assert property (@(posedge wclk) disable iff (!resetn)
        run_enable == run_ref)
        else flag_mismatch("run_enable does not follow busy, fail and pause");

    cpu_rd_chk: assert property (@(posedge wclk) disable iff (!resetn)
        live_edges >= 1 |->
            cpu_rd == $past(phf_ref && !load_beat && (rom_sel || wram_rd_req)))
        else flag_mismatch("cpu_rd not two cycles after sysclkf_ce");

    cpu_wr_chk: assert property (@(posedge wclk) disable iff (!resetn)
        live_edges >= 1 |->
            cpu_wr == $past(load_beat
                            || (!(rom_sel && phf_ref) && wram_wr_req && phr_ref)))
        else flag_mismatch("cpu_wr not after a loader byte or the rise phase");

    loader_req_chk: assert property (@(posedge wclk) disable iff (!resetn)
        load_beat |=>
            (cpu_addr == $past(exp_load_addr)
             && cpu_din == {2{$past(loader_data)}}
             && cpu_ds == ($past(exp_load_addr[0]) ? 2'b10 : 2'b01)
             && !cpu_port))
        else flag_mismatch("loader write address, data or lanes wrong");

    rom_req_chk: assert property (@(posedge wclk) disable iff (!resetn)
        (!load_beat && rom_sel && phf_ref) |=>
            (cpu_addr == $past(rom_addr) && cpu_ds == 2'b11
             && cpu_din == 16'h0000 && !cpu_port))
        else flag_mismatch("rom read request fields wrong");

    wram_req_chk: assert property (@(posedge wclk) disable iff (!resetn)
        (!load_beat && !(rom_sel && phf_ref) && (wram_rd_req || wram_wr_req)) |=>
            (cpu_addr == {`WRAM_BANK_PREFIX, $past(wram_addr)}
             && cpu_din == {2{$past(wram_d)}}
             && cpu_ds == ($past(wram_addr[0]) ? 2'b10 : 2'b01)
             && cpu_port))
        else flag_mismatch("wram request address, data, lanes or port wrong");

    idle_bus_chk: assert property (@(posedge wclk) disable iff (!resetn)
        (!load_beat && !(rom_sel && phf_ref) && !wram_rd_req && !wram_wr_req) |=>
            (cpu_addr == '0 && cpu_din == '0 && cpu_ds == '0 && !cpu_port))
        else flag_mismatch("request bus not zero with no grant");

    // combinational read data steering
    rom_word_q_chk: assert property (@(posedge wclk) disable iff (!resetn)
        (rom_word || !rom_addr[0]) |-> rom_q == cpu_port0)
        else flag_mismatch("rom_q not the returned word as is");

    rom_swap_q_chk: assert property (@(posedge wclk) disable iff (!resetn)
        (!rom_word && rom_addr[0]) |->
            (rom_q[15:8] == cpu_port0[7:0] && rom_q[7:0] == cpu_port0[15:8]))
        else flag_mismatch("rom_q bytes not swapped for an odd byte fetch");

    // byte lane index is address bit 0
    wram_q_chk: assert property (@(posedge wclk) disable iff (!resetn)
        wram_q == cpu_port1[{wram_addr[0], 3'b000} +: 8])
        else flag_mismatch("wram_q picked the wrong byte");

    bsram_q_chk: assert property (@(posedge wclk) disable iff (!resetn)
        bsram_q == bsram_dout[{bsram_addr[0], 3'b000} +: 8])
        else flag_mismatch("bsram_q picked the wrong byte");

    bsram_rd_chk: assert property (@(posedge wclk) disable iff (!resetn)
        live_edges >= 1 |->
            bsram_req_rd == $past(!bsram_ce_n && phf_ref
                                  && (!bsram_rd_n
                                      || map_ctrl[7:4] == `MAP_BSRAM_OPEN_READ)))
        else flag_mismatch("bsram_req_rd wrong for phase or map mode");

    bsram_wr_chk: assert property (@(posedge wclk) disable iff (!resetn)
        live_edges >= 1 |->
            bsram_req_wr == $past(!bsram_ce_n && !bsram_we_n && phr_ref))
        else flag_mismatch("bsram_req_wr wrong for rise phase");

    bsram_bus_chk: assert property (@(posedge wclk) disable iff (!resetn)
        live_edges >= 1 |->
            (bsram_req_addr == $past(bsram_addr) && bsram_req_din == $past(bsram_d)))
        else flag_mismatch("bsram request address or data not registered");

    task automatic init_inputs();
        sdram_busy   <= 1'b1;  // controller busy until released
        loader_fail  <= 1'b0;
        frame_pause  <= 1'b0;
        sysclkf_ce   <= 1'b0;
        sysclkr_ce   <= 1'b0;
        loading      <= 1'b0;
        loader_valid <= 1'b0;
        loader_data  <= 8'h00;
        map_ctrl     <= 8'h00;
        rom_addr     <= '0;
        rom_ce_n     <= 1'b1;
        rom_word     <= 1'b0;
        wram_addr    <= '0;
        wram_ce_n    <= 1'b1;
        wram_rd_n    <= 1'b1;
        wram_we_n    <= 1'b1;
        wram_d       <= 8'h00;
        bsram_addr   <= '0;
        bsram_ce_n   <= 1'b1;
        bsram_rd_n   <= 1'b1;
        bsram_we_n   <= 1'b1;
        bsram_d      <= 8'h00;
        cpu_port0    <= 16'h0000;
        cpu_port1    <= 16'h0000;
        bsram_dout   <= 16'h0000;
        exp_load_addr <= '0;
    endtask

    // sdram model puts fresh words on the return buses at each rising edge
    task automatic advance_cycle();
        @(posedge wclk);
        cpu_port0  <= 16'(take_bits(16));
        cpu_port1  <= 16'(take_bits(16));
        bsram_dout <= 16'(take_bits(16));
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        @(negedge wclk);
        while (resetn !== 1'b1 && n < 100) begin
            @(negedge wclk);
            n++;
        end
        if (resetn !== 1'b1) flag_timeout("reset was never released");
    endtask

    // run_enable checked mid-cycle until it reaches the level
    task automatic wait_run_level(input logic level);
        int n;
        n = 0;
        @(negedge wclk);
        while (run_enable !== level && n < 20) begin
            advance_cycle();
            @(negedge wclk);
            n++;
        end
        if (run_enable !== level) flag_timeout("run_enable never reached the expected level");
    endtask

    // one fall phase then one rise phase with random spacing
    task automatic pulse_phases();
        int gap;
        gap = 1 + int'(take_bits(2));
        advance_cycle();
        sysclkf_ce <= 1'b1;
        advance_cycle();
        sysclkf_ce <= 1'b0;
        repeat (gap) advance_cycle();
        sysclkr_ce <= 1'b1;
        advance_cycle();
        sysclkr_ce <= 1'b0;
        repeat (gap) advance_cycle();
    endtask

    task automatic exercise_run_gate();
        repeat (3) advance_cycle();
        sdram_busy <= 1'b0;
        wait_run_level(1'b1);
        advance_cycle();
        rom_addr <= snes_addr_t'(take_bits(24));
        rom_ce_n <= 1'b0;
        pulse_phases();
        frame_pause <= 1'b1;  // phases while paused must not strobe
        pulse_phases();
        wait_run_level(1'b0);
        advance_cycle();
        frame_pause <= 1'b0;
        wait_run_level(1'b1);
        // pause and fail flicker mid-run
        repeat (24) begin
            advance_cycle();
            frame_pause <= (take_bits(2) == 0);
            loader_fail <= (take_bits(4) == 0);
            sysclkf_ce  <= 1'(take_bits(1));
            sysclkr_ce  <= 1'(take_bits(1));
        end
        advance_cycle();
        frame_pause <= 1'b0;
        loader_fail <= 1'b0;
        sysclkf_ce  <= 1'b0;
        sysclkr_ce  <= 1'b0;
        wait_run_level(1'b1);
        advance_cycle();
    endtask

    // loader bytes with gaps while rom keeps asking
    task automatic load_cartridge(input int n_bytes);
        int sent;
        sent = 0;
        loading      <= 1'b1;  // rise cycle carries no byte
        loader_valid <= 1'b0;
        rom_ce_n     <= 1'b0;
        while (sent < n_bytes) begin
            advance_cycle();
            sysclkf_ce <= 1'(take_bits(1));
            rom_addr   <= snes_addr_t'(take_bits(24));
            if (take_bits(2) == 0) begin
                loader_valid <= 1'b0;
            end else begin
                loader_valid  <= 1'b1;
                loader_data   <= 8'(take_bits(8));
                exp_load_addr <= snes_addr_t'(sent);
                sent++;
            end
        end
        advance_cycle();
        loader_valid <= 1'b0;
        sysclkf_ce   <= 1'b0;
        advance_cycle();
        loading <= 1'b0;
        repeat (2) advance_cycle();
    endtask

    task automatic read_rom(input int n_reads);
        repeat (n_reads) begin
            rom_addr  <= snes_addr_t'(take_bits(24));
            rom_word  <= 1'(take_bits(1));
            rom_ce_n  <= (take_bits(3) == 0);
            wram_addr <= wram_addr_t'(take_bits(17));
            wram_ce_n <= 1'(take_bits(1));  // wram competes and loses on phase_f
            wram_rd_n <= 1'b0;
            wram_we_n <= 1'b1;
            pulse_phases();
        end
        rom_ce_n  <= 1'b1;
        wram_ce_n <= 1'b1;
    endtask

    task automatic access_wram(input int n_accesses);
        logic do_write;
        repeat (n_accesses) begin
            do_write  = 1'(take_bits(1));
            wram_addr <= wram_addr_t'(take_bits(17));
            wram_d    <= 8'(take_bits(8));
            wram_ce_n <= (take_bits(3) == 0);
            wram_rd_n <= do_write;
            wram_we_n <= !do_write;
            pulse_phases();
        end
        wram_ce_n <= 1'b1;
        wram_rd_n <= 1'b1;
        wram_we_n <= 1'b1;
    endtask

    task automatic access_bsram(input int n_accesses, input logic [3:0] map_mode);
        map_ctrl <= {map_mode, 4'(take_bits(4))};
        repeat (n_accesses) begin
            bsram_addr <= bsram_addr_t'(take_bits(20));
            bsram_d    <= 8'(take_bits(8));
            bsram_ce_n <= (take_bits(3) == 0);
            bsram_rd_n <= 1'(take_bits(1));  // high half the time for the open read case
            bsram_we_n <= 1'(take_bits(1));
            pulse_phases();
        end
        bsram_ce_n <= 1'b1;
    endtask

    initial begin
        init_inputs();
        wait_reset_release();
        advance_cycle();
        exercise_run_gate();
        load_cartridge(20);
        load_cartridge(12);  // second load restarts at zero
        read_rom(24);
        access_wram(32);
        access_bsram(24, 4'h3);
        access_bsram(24, `MAP_BSRAM_OPEN_READ);
        repeat (4) advance_cycle();
        $display("TEST RESULT: PASS");
        $finish;
    end

    // overall limit on the run
    initial begin
        repeat (20000) @(posedge wclk);
        flag_timeout("simulation ran past its cycle limit");
    end

endmodule

// File: snes_mem_front.f
+incdir+.
snes_mem_pkg.sv
loader_addr_counter.sv
sdram_req_arbiter.sv
bsram_req_port.sv
snes_mem_front.sv
tb_clock_gen.sv
snes_mem_front_tb.sv

// File: Bender.yml
package:
  name: snes_mem_front

sources:
  - include_dirs:
      - .
    files:
      - snes_mem_pkg.sv
      - loader_addr_counter.sv
      - sdram_req_arbiter.sv
      - bsram_req_port.sv
      - snes_mem_front.sv
      - target: test
        include_dirs:
          - .
        files:
          - tb_clock_gen.sv
          - snes_mem_front_tb.sv
